/* compile.f */
logic/hyper_pkg.sv
logic/axil_pkg.sv
logic/axil_frontend.sv
logic/cfg_regs.sv
logic/ca_builder.sv
logic/hyper_phy_seq.sv
logic/hyperbus_ctrl.sv
testbench/hyper_mem_model.sv
testbench/tb_hyperbus_ctrl.sv

/* logic/axil_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_frontend (
    input  logic                 clk_sys_i,
    input  logic                 reset_i,
    input  axil_pkg::axil_req_t  axil_req_i,
    output axil_pkg::axil_rsp_t  axil_rsp_o,
    output logic                 cfg_req_o,
    output logic                 cfg_write_o,
    output logic [7:0]           cfg_ofs_o,
    output logic [31:0]          cfg_wdata_o,
    output logic [3:0]           cfg_strb_o,
    input  logic [31:0]          cfg_rdata_i,
    input  logic                 cfg_err_i,
    output logic                 mem_valid_o,
    output hyper_pkg::mem_trans_t mem_trans_o,
    input  logic                 mem_busy_i,
    input  hyper_pkg::mem_resp_t mem_resp_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_MEM,
        ST_RESPOND
    } fe_state_e;

    fe_state_e            state_q;
    fe_state_e            state_d;
    logic                 ready_q;
    logic                 accept;
    logic                 wr_both;
    logic                 wr_hs;
    logic                 rd_hs;
    logic                 is_cfg;
    logic                 is_write_q;
    logic [31:0]          addr;
    logic [31:0]          rdata_q;
    axil_pkg::axil_resp_e resp_q;

    // Write needs AW and W together, and beats a concurrent read
    assign wr_both = axil_req_i.awvalid & axil_req_i.wvalid;
    assign accept  = ready_q & ~mem_busy_i;
    assign wr_hs   = accept & wr_both;
    assign rd_hs   = accept & axil_req_i.arvalid & ~wr_both;
    assign addr    = wr_both ? axil_req_i.awaddr : axil_req_i.araddr;
    assign is_cfg  = addr[axil_pkg::CFG_SPACE_BIT];

    assign cfg_req_o   = (wr_hs | rd_hs) & is_cfg;
    assign cfg_write_o = wr_hs;
    assign cfg_ofs_o   = addr[7:0];
    assign cfg_wdata_o = axil_req_i.wdata;
    assign cfg_strb_o  = axil_req_i.wstrb;

    // Byte address to 32-bit word address
    assign mem_valid_o = (wr_hs | rd_hs) & ~is_cfg;
    always_comb begin
        mem_trans_o.write = wr_hs;
        mem_trans_o.addr  = {2'b00, addr[31:2]};
        mem_trans_o.wdata = axil_req_i.wdata;
        mem_trans_o.strb  = axil_req_i.wstrb;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cfg_req_o) begin
                    state_d = ST_RESPOND;
                end else if (mem_valid_o) begin
                    state_d = ST_WAIT_MEM;
                end
            end
            ST_WAIT_MEM: begin
                if (mem_resp_i.done) begin
                    state_d = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                if (is_write_q ? axil_req_i.bready : axil_req_i.rready) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_sys_i) begin
        if (reset_i) begin
            state_q    <= ST_IDLE;
            ready_q    <= 1'b0;
            is_write_q <= 1'b0;
        end else begin
            state_q <= state_d;
            ready_q <= (state_d == ST_IDLE);
            if (wr_hs | rd_hs) begin
                is_write_q <= wr_hs;
            end
        end
    end

    // Response payload from whichever path finished
    always_ff @(posedge clk_sys_i) begin
        if (cfg_req_o) begin
            rdata_q <= cfg_rdata_i;
            resp_q  <= cfg_err_i ? axil_pkg::SLVERR : axil_pkg::OKAY;
        end else if (state_q == ST_WAIT_MEM && mem_resp_i.done) begin
            rdata_q <= mem_resp_i.rdata;
            resp_q  <= axil_pkg::OKAY;
        end
    end

    always_comb begin
        axil_rsp_o.awready = wr_hs;
        axil_rsp_o.wready  = wr_hs;
        axil_rsp_o.arready = rd_hs;
        axil_rsp_o.bresp   = resp_q;
        axil_rsp_o.bvalid  = (state_q == ST_RESPOND) & is_write_q;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = resp_q;
        axil_rsp_o.rvalid  = (state_q == ST_RESPOND) & ~is_write_q;
    end

endmodule

`default_nettype wire

/* logic/axil_pkg.sv */
`default_nettype none

package axil_pkg;

    // Address bit selecting the register space
    localparam int CFG_SPACE_BIT = 31;

    localparam logic [7:0] CFG_LATENCY_OFS  = 8'h00;
    localparam logic [7:0] CFG_RECOVERY_OFS = 8'h04;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    typedef struct packed {
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [31:0] araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        axil_resp_e  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        axil_resp_e  rresp;
        logic        rvalid;
    } axil_rsp_t;

endpackage

`default_nettype wire

/* logic/ca_builder.sv */
`timescale 1ns/1ps
`default_nettype none

module ca_builder (
    input  logic                  clk_sys_i,
    input  logic                  reset_i,
    input  logic                  mem_valid_i,
    input  hyper_pkg::mem_trans_t mem_trans_i,
    input  logic                  seq_take_i,
    output logic                  ca_valid_o,
    output logic [47:0]           ca_word_o,
    output logic [31:0]           wdata_o,
    output logic [3:0]            mask_o,
    output logic                  write_o
);

    logic                  ca_valid_q;
    hyper_pkg::mem_trans_t trans_q;

    always_ff @(posedge clk_sys_i) begin
        if (reset_i) begin
            ca_valid_q <= 1'b0;
        end else if (mem_valid_i) begin
            ca_valid_q <= 1'b1;
        end else if (seq_take_i) begin
            ca_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (mem_valid_i) begin
            trans_q <= mem_trans_i;
        end
    end

    // Read flag, memory space, linear burst, upper and lower address
    assign ca_word_o = {~trans_q.write, 1'b0, 1'b1, trans_q.addr[31:3],
                        13'd0, trans_q.addr[2:0]};

    assign ca_valid_o = ca_valid_q;
    assign wdata_o    = trans_q.wdata;
    assign mask_o     = ~trans_q.strb;
    assign write_o    = trans_q.write;

endmodule

`default_nettype wire

/* logic/cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_regs (
    input  logic                   clk_sys_i,
    input  logic                   reset_i,
    input  logic                   cfg_req_i,
    input  logic                   cfg_write_i,
    input  logic [7:0]             cfg_ofs_i,
    input  logic [31:0]            cfg_wdata_i,
    input  logic [3:0]             cfg_strb_i,
    output logic [31:0]            cfg_rdata_o,
    output logic                   cfg_err_o,
    output hyper_pkg::timing_cfg_t timing_o
);

    hyper_pkg::timing_cfg_t timing_q;
    logic                   hit_lat;
    logic                   hit_rec;
    logic                   wr_en;

    assign hit_lat = (cfg_ofs_i == axil_pkg::CFG_LATENCY_OFS);
    assign hit_rec = (cfg_ofs_i == axil_pkg::CFG_RECOVERY_OFS);
    assign wr_en   = cfg_req_i & cfg_write_i & cfg_strb_i[0];

    always_ff @(posedge clk_sys_i) begin
        if (reset_i) begin
            timing_q.latency  <= hyper_pkg::LATENCY_RESET;
            timing_q.recovery <= hyper_pkg::RECOVERY_RESET;
        end else if (wr_en) begin
            if (hit_lat) begin
                timing_q.latency <= cfg_wdata_i[3:0];
            end
            if (hit_rec) begin
                timing_q.recovery <= cfg_wdata_i[3:0];
            end
        end
    end

    // Read-back is zero-extended
    always_comb begin
        cfg_rdata_o = 32'd0;
        if (hit_lat) begin
            cfg_rdata_o[3:0] = timing_q.latency;
        end else if (hit_rec) begin
            cfg_rdata_o[3:0] = timing_q.recovery;
        end
    end

    assign cfg_err_o = cfg_req_i & ~(hit_lat | hit_rec);
    assign timing_o  = timing_q;

endmodule

`default_nettype wire

/* logic/hyper_phy_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module hyper_phy_seq (
    input  logic                   clk_sys_i,
    input  logic                   reset_i,
    input  hyper_pkg::timing_cfg_t timing_i,
    input  logic                   ca_valid_i,
    input  logic [47:0]            ca_word_i,
    input  logic [31:0]            wdata_i,
    input  logic [3:0]             mask_i,
    input  logic                   write_i,
    output logic                   seq_take_o,
    output logic                   busy_o,
    output hyper_pkg::mem_resp_t   mem_resp_o,
    output logic                   hyper_cs_no,
    output logic                   hyper_ck_o,
    output logic [7:0]             hyper_dq_o,
    output logic                   hyper_dq_oe_o,
    output logic                   hyper_rwds_o,
    output logic                   hyper_rwds_oe_o,
    input  logic                   hyper_rwds_i,
    input  logic [7:0]             hyper_dq_i,
    output logic                   hyper_reset_no
);

    hyper_pkg::phy_state_e state_q;
    hyper_pkg::phy_state_e state_d;
    logic [2:0]            byte_cnt_q;
    logic [3:0]            wait_cnt_q;
    logic [4:0]            wait_next;
    logic                  ck_q;
    logic                  reset_n_q;
    logic                  active_q;
    logic                  active_d;
    logic                  data_step;
    logic                  data_done;
    logic [31:0]           rdata_q;

    assign wait_next = {1'b0, wait_cnt_q} + 5'd1;

    // Reads advance only on RWDS strobes from the device
    assign data_step = write_i | hyper_rwds_i;
    assign data_done = (state_q == hyper_pkg::DATA) & data_step &
                       (byte_cnt_q == 3'(hyper_pkg::DATA_BYTES - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            hyper_pkg::IDLE: begin
                if (ca_valid_i) begin
                    state_d = hyper_pkg::CMD;
                end
            end
            hyper_pkg::CMD: begin
                if (byte_cnt_q == 3'(hyper_pkg::CA_BYTES - 1)) begin
                    state_d = (timing_i.latency == 4'd0) ? hyper_pkg::DATA
                                                        : hyper_pkg::LATENCY;
                end
            end
            hyper_pkg::LATENCY: begin
                if (wait_next == {1'b0, timing_i.latency}) begin
                    state_d = hyper_pkg::DATA;
                end
            end
            hyper_pkg::DATA: begin
                if (data_done) begin
                    state_d = hyper_pkg::RECOVER;
                end
            end
            hyper_pkg::RECOVER: begin
                // At least one cycle with CS high
                if (wait_next >= {1'b0, timing_i.recovery}) begin
                    state_d = hyper_pkg::IDLE;
                end
            end
            default: state_d = hyper_pkg::IDLE;
        endcase
    end

    assign active_q = (state_q == hyper_pkg::CMD) | (state_q == hyper_pkg::LATENCY) |
                      (state_q == hyper_pkg::DATA);
    assign active_d = (state_d == hyper_pkg::CMD) | (state_d == hyper_pkg::LATENCY) |
                      (state_d == hyper_pkg::DATA);

    always_ff @(posedge clk_sys_i) begin
        if (reset_i) begin
            state_q    <= hyper_pkg::IDLE;
            byte_cnt_q <= 3'd0;
            wait_cnt_q <= 4'd0;
            ck_q       <= 1'b0;
            reset_n_q  <= 1'b0;
        end else begin
            state_q   <= state_d;
            reset_n_q <= 1'b1;
            ck_q      <= active_d ? ~ck_q : 1'b0;
            if (state_d != state_q) begin
                byte_cnt_q <= 3'd0;
                wait_cnt_q <= 4'd0;
            end else begin
                if (state_q == hyper_pkg::CMD ||
                        (state_q == hyper_pkg::DATA && data_step)) begin
                    byte_cnt_q <= byte_cnt_q + 3'd1;
                end
                if (state_q == hyper_pkg::LATENCY || state_q == hyper_pkg::RECOVER) begin
                    wait_cnt_q <= wait_cnt_q + 4'd1;
                end
            end
        end
    end

    // Read bytes arrive least significant first
    always_ff @(posedge clk_sys_i) begin
        if (state_q == hyper_pkg::DATA && !write_i && hyper_rwds_i) begin
            rdata_q <= {hyper_dq_i, rdata_q[31:8]};
        end
    end

    assign mem_resp_o.rdata = {hyper_dq_i, rdata_q[31:8]};
    assign mem_resp_o.done  = data_done;

    assign seq_take_o = (state_q == hyper_pkg::IDLE) & ca_valid_i;
    assign busy_o     = (state_q != hyper_pkg::IDLE);

    // CA goes out MSB first, write data LSB first
    assign hyper_dq_o = (state_q == hyper_pkg::CMD) ? ca_word_i[47 - 8*byte_cnt_q -: 8]
                                                    : wdata_i[8*byte_cnt_q[1:0] +: 8];
    assign hyper_dq_oe_o   = (state_q == hyper_pkg::CMD) |
                             ((state_q == hyper_pkg::DATA) & write_i);
    assign hyper_rwds_o    = mask_i[byte_cnt_q[1:0]];
    assign hyper_rwds_oe_o = (state_q == hyper_pkg::DATA) & write_i;
    assign hyper_cs_no     = ~active_q;
    assign hyper_ck_o      = ck_q;
    assign hyper_reset_no  = reset_n_q;

endmodule

`default_nettype wire

/* logic/hyper_pkg.sv */
`default_nettype none

package hyper_pkg;

    // Bytes per command-address sequence and per data word
    localparam int CA_BYTES   = 6;
    localparam int DATA_BYTES = 4;

    localparam logic [3:0] LATENCY_RESET  = 4'd6;
    localparam logic [3:0] RECOVERY_RESET = 4'd2;

    // One single-word memory access
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
    } mem_trans_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        done;
    } mem_resp_t;

    typedef struct packed {
        logic [3:0] latency;
        logic [3:0] recovery;
    } timing_cfg_t;

    typedef enum logic [2:0] {
        IDLE,
        CMD,
        LATENCY,
        DATA,
        RECOVER
    } phy_state_e;

endpackage

`default_nettype wire

/* logic/hyperbus_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module hyperbus_ctrl (
    input  logic                clk_sys_i,
    input  logic                reset_i,
    input  axil_pkg::axil_req_t axil_req_i,
    output axil_pkg::axil_rsp_t axil_rsp_o,
    output logic                hyper_cs_no,
    output logic                hyper_ck_o,
    output logic [7:0]          hyper_dq_o,
    output logic                hyper_dq_oe_o,
    output logic                hyper_rwds_o,
    output logic                hyper_rwds_oe_o,
    input  logic                hyper_rwds_i,
    input  logic [7:0]          hyper_dq_i,
    output logic                hyper_reset_no
);

    logic                   cfg_req;
    logic                   cfg_write;
    logic [7:0]             cfg_ofs;
    logic [31:0]            cfg_wdata;
    logic [3:0]             cfg_strb;
    logic [31:0]            cfg_rdata;
    logic                   cfg_err;
    hyper_pkg::timing_cfg_t timing;

    logic                   mem_valid;
    hyper_pkg::mem_trans_t  mem_trans;
    logic                   mem_busy;
    hyper_pkg::mem_resp_t   mem_resp;

    logic                   ca_valid;
    logic [47:0]            ca_word;
    logic [31:0]            seq_wdata;
    logic [3:0]             seq_mask;
    logic                   seq_write;
    logic                   seq_take;

    axil_frontend i_axil_frontend (
        .clk_sys_i   ( clk_sys_i  ),
        .reset_i     ( reset_i    ),
        .axil_req_i  ( axil_req_i ),
        .axil_rsp_o  ( axil_rsp_o ),
        .cfg_req_o   ( cfg_req    ),
        .cfg_write_o ( cfg_write  ),
        .cfg_ofs_o   ( cfg_ofs    ),
        .cfg_wdata_o ( cfg_wdata  ),
        .cfg_strb_o  ( cfg_strb   ),
        .cfg_rdata_i ( cfg_rdata  ),
        .cfg_err_i   ( cfg_err    ),
        .mem_valid_o ( mem_valid  ),
        .mem_trans_o ( mem_trans  ),
        .mem_busy_i  ( mem_busy   ),
        .mem_resp_i  ( mem_resp   )
    );

    cfg_regs i_cfg_regs (
        .clk_sys_i   ( clk_sys_i ),
        .reset_i     ( reset_i   ),
        .cfg_req_i   ( cfg_req   ),
        .cfg_write_i ( cfg_write ),
        .cfg_ofs_i   ( cfg_ofs   ),
        .cfg_wdata_i ( cfg_wdata ),
        .cfg_strb_i  ( cfg_strb  ),
        .cfg_rdata_o ( cfg_rdata ),
        .cfg_err_o   ( cfg_err   ),
        .timing_o    ( timing    )
    );

    ca_builder i_ca_builder (
        .clk_sys_i   ( clk_sys_i ),
        .reset_i     ( reset_i   ),
        .mem_valid_i ( mem_valid ),
        .mem_trans_i ( mem_trans ),
        .seq_take_i  ( seq_take  ),
        .ca_valid_o  ( ca_valid  ),
        .ca_word_o   ( ca_word   ),
        .wdata_o     ( seq_wdata ),
        .mask_o      ( seq_mask  ),
        .write_o     ( seq_write )
    );

    hyper_phy_seq i_hyper_phy_seq (
        .clk_sys_i       ( clk_sys_i       ),
        .reset_i         ( reset_i         ),
        .timing_i        ( timing          ),
        .ca_valid_i      ( ca_valid        ),
        .ca_word_i       ( ca_word         ),
        .wdata_i         ( seq_wdata       ),
        .mask_i          ( seq_mask        ),
        .write_i         ( seq_write       ),
        .seq_take_o      ( seq_take        ),
        .busy_o          ( mem_busy        ),
        .mem_resp_o      ( mem_resp        ),
        .hyper_cs_no     ( hyper_cs_no     ),
        .hyper_ck_o      ( hyper_ck_o      ),
        .hyper_dq_o      ( hyper_dq_o      ),
        .hyper_dq_oe_o   ( hyper_dq_oe_o   ),
        .hyper_rwds_o    ( hyper_rwds_o    ),
        .hyper_rwds_oe_o ( hyper_rwds_oe_o ),
        .hyper_rwds_i    ( hyper_rwds_i    ),
        .hyper_dq_i      ( hyper_dq_i      ),
        .hyper_reset_no  ( hyper_reset_no  )
    );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -f compile.f --top-module tb_hyperbus_ctrl; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_hyperbus_ctrl 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* testbench/hyper_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module hyper_mem_model (
    input  logic       clk_i,
    input  logic       cs_ni,
    input  logic       ck_i,
    input  logic [7:0] dq_i,
    input  logic       dq_oe_i,
    input  logic       rwds_i,
    input  logic       rwds_oe_i,
    input  logic [3:0] latency_i,
    output logic [7:0] dq_o,
    output logic       rwds_o,
    output logic       bus_err_o
);

    logic [7:0]  mem [256];
    logic [47:0] ca_q;
    logic [31:0] rng_q;
    logic        ck_prev_q;
    int          phase_q;
    int          delay_q;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'h96;
        end
        ca_q      = '0;
        rng_q     = 32'hab0a_f7ac;
        ck_prev_q = 1'b0;
        phase_q   = 0;
        delay_q   = 0;
        dq_o      = 8'h00;
        rwds_o    = 1'b0;
        bus_err_o = 1'b0;
    end

    // Sampled and driven mid-cycle, one bus byte per ck phase
    always @(negedge clk_i) begin
        int          lat;
        int          slot;
        logic [5:0]  word;
        logic [31:0] rnd;
        lat  = int'(latency_i);
        slot = phase_q - 6 - lat;
        word = {ca_q[18:16], ca_q[2:0]};
        rnd  = xorshift(rng_q);
        ck_prev_q <= ck_i;
        rwds_o    <= 1'b0;
        dq_o      <= 8'h00;
        if (cs_ni) begin
            phase_q <= 0;
            if (ck_i) begin
                bus_err_o <= 1'b1;
            end
        end else begin
            phase_q <= phase_q + 1;
            if (ck_i == ck_prev_q) begin
                bus_err_o <= 1'b1;
            end
            // Fresh extra read delay per access
            if (phase_q == 0) begin
                rng_q   <= rnd;
                delay_q <= int'(rnd[1:0]);
            end
            if (phase_q < 6) begin
                ca_q <= {ca_q[39:0], dq_i};
                if (!dq_oe_i) begin
                    bus_err_o <= 1'b1;
                end
            end
            // Memory space, linear burst, reserved bits clear
            if (phase_q == 6 && (ca_q[46] || !ca_q[45] || ca_q[15:3] != 13'd0)) begin
                bus_err_o <= 1'b1;
            end
            if (slot >= 0) begin
                if (!ca_q[47]) begin
                    if (slot < 4) begin
                        if (!dq_oe_i || !rwds_oe_i) begin
                            bus_err_o <= 1'b1;
                        end
                        if (!rwds_i) begin
                            mem[{word, 2'(slot)}] <= dq_i;
                        end
                    end
                end else begin
                    if (dq_oe_i || rwds_oe_i) begin
                        bus_err_o <= 1'b1;
                    end
                    if (slot >= delay_q && slot < delay_q + 4) begin
                        rwds_o <= 1'b1;
                        dq_o   <= mem[{word, 2'(slot - delay_q)}];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_hyperbus_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_hyperbus_ctrl;

    localparam int NUM_ROWS   = 22;
    localparam int ROW_CYCLES = 64;
    localparam int MAX_CYCLES = NUM_ROWS * ROW_CYCLES;

    localparam logic WR = 1'b1;
    localparam logic RD = 1'b0;
    localparam axil_pkg::axil_resp_e OK  = axil_pkg::OKAY;
    localparam axil_pkg::axil_resp_e ERR = axil_pkg::SLVERR;

    typedef struct packed {
        logic                 write;
        logic [31:0]          addr;
        logic [31:0]          data;
        logic [3:0]           strb;
        axil_pkg::axil_resp_e resp;
        logic [31:0]          exp_data;
        logic [3:0]           lat;
        logic [3:0]           hold;
    } row_t;

    logic                clk;
    logic                reset;
    axil_pkg::axil_req_t req;
    axil_pkg::axil_rsp_t rsp;
    logic                cs_n;
    logic                ck;
    logic [7:0]          dq_out;
    logic                dq_oe;
    logic                rwds_out;
    logic                rwds_oe;
    logic                rwds_in;
    logic [7:0]          dq_in;
    logic                reset_n;
    logic                bus_err;
    logic [3:0]          model_lat;
    logic                wr_hs_q;
    logic                rd_hs_q;
    int                  cycle_cnt;
    row_t                rows [NUM_ROWS];

    hyperbus_ctrl i_dut (
        .clk_sys_i       ( clk      ),
        .reset_i         ( reset    ),
        .axil_req_i      ( req      ),
        .axil_rsp_o      ( rsp      ),
        .hyper_cs_no     ( cs_n     ),
        .hyper_ck_o      ( ck       ),
        .hyper_dq_o      ( dq_out   ),
        .hyper_dq_oe_o   ( dq_oe    ),
        .hyper_rwds_o    ( rwds_out ),
        .hyper_rwds_oe_o ( rwds_oe  ),
        .hyper_rwds_i    ( rwds_in  ),
        .hyper_dq_i      ( dq_in    ),
        .hyper_reset_no  ( reset_n  )
    );

    hyper_mem_model i_mem (
        .clk_i     ( clk       ),
        .cs_ni     ( cs_n      ),
        .ck_i      ( ck        ),
        .dq_i      ( dq_out    ),
        .dq_oe_i   ( dq_oe     ),
        .rwds_i    ( rwds_out  ),
        .rwds_oe_i ( rwds_oe   ),
        .latency_i ( model_lat ),
        .dq_o      ( dq_in     ),
        .rwds_o    ( rwds_in   ),
        .bus_err_o ( bus_err   )
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // Handshakes as seen at the rising edge
    always @(posedge clk) begin
        wr_hs_q   <= req.awvalid & req.wvalid & rsp.awready & rsp.wready;
        rd_hs_q   <= req.arvalid & rsp.arready;
        cycle_cnt <= cycle_cnt + 1;
        assert (cycle_cnt < MAX_CYCLES) else begin
            fail_now($sformatf("timeout after %0d cycles waiting for the DUT", cycle_cnt));
        end
    end

    function automatic logic response_valid(input logic write);
        return write ? rsp.bvalid : rsp.rvalid;
    endfunction

    function automatic row_t table_row(input logic write, input logic [31:0] addr,
                                       input logic [31:0] data, input logic [3:0] strb,
                                       input axil_pkg::axil_resp_e resp,
                                       input logic [31:0] exp_data, input int lat,
                                       input int hold);
        row_t r;
        r.write    = write;
        r.addr     = addr;
        r.data     = data;
        r.strb     = strb;
        r.resp     = resp;
        r.exp_data = exp_data;
        r.lat      = 4'(lat);
        r.hold     = 4'(hold);
        return r;
    endfunction

    task automatic load_rows();
        rows[0]  = table_row(WR, 32'h0000_0010, 32'h1234_5678, 4'hf, OK, 32'h0, 6, 0);
        rows[1]  = table_row(WR, 32'h0000_0024, 32'ha5c3_0f96, 4'hf, OK, 32'h0, 6, 0);
        rows[2]  = table_row(WR, 32'h0000_01f8, 32'hdead_beef, 4'hf, OK, 32'h0, 6, 4);
        rows[3]  = table_row(RD, 32'h0000_0010, 32'h0, 4'h0, OK, 32'h1234_5678, 6, 0);
        rows[4]  = table_row(RD, 32'h0000_0024, 32'h0, 4'h0, OK, 32'ha5c3_0f96, 6, 0);
        rows[5]  = table_row(RD, 32'h0000_01f8, 32'h0, 4'h0, OK, 32'hdead_beef, 6, 5);
        // Bytes 0 and 2 only
        rows[6]  = table_row(WR, 32'h0000_0010, 32'hffee_ddcc, 4'h5, OK, 32'h0, 6, 0);
        rows[7]  = table_row(RD, 32'h0000_0010, 32'h0, 4'h0, OK, 32'h12ee_56cc, 6, 0);
        rows[8]  = table_row(WR, 32'h0000_01f8, 32'h0102_0304, 4'h8, OK, 32'h0, 6, 0);
        rows[9]  = table_row(RD, 32'h0000_01f8, 32'h0, 4'h0, OK, 32'h01ad_beef, 6, 0);
        // Latency down to 3
        rows[10] = table_row(WR, 32'h8000_0000, 32'h0000_0003, 4'hf, OK, 32'h0, 6, 0);
        rows[11] = table_row(RD, 32'h8000_0000, 32'h0, 4'h0, OK, 32'h0000_0003, 3, 0);
        rows[12] = table_row(WR, 32'h0000_0024, 32'h5566_7788, 4'hf, OK, 32'h0, 3, 0);
        rows[13] = table_row(RD, 32'h0000_0024, 32'h0, 4'h0, OK, 32'h5566_7788, 3, 0);
        rows[14] = table_row(RD, 32'h0000_0010, 32'h0, 4'h0, OK, 32'h12ee_56cc, 3, 0);
        rows[15] = table_row(WR, 32'h8000_0008, 32'h0000_000f, 4'hf, ERR, 32'h0, 3, 0);
        rows[16] = table_row(RD, 32'h8000_0010, 32'h0, 4'h0, ERR, 32'h0, 3, 0);
        rows[17] = table_row(RD, 32'h8000_0000, 32'h0, 4'h0, OK, 32'h0000_0003, 3, 0);
        rows[18] = table_row(WR, 32'h8000_0004, 32'h0000_0005, 4'hf, OK, 32'h0, 3, 0);
        rows[19] = table_row(RD, 32'h8000_0004, 32'h0, 4'h0, OK, 32'h0000_0005, 3, 0);
        rows[20] = table_row(WR, 32'h0000_003c, 32'h0bad_cafe, 4'hf, OK, 32'h0, 3, 0);
        rows[21] = table_row(RD, 32'h0000_003c, 32'h0, 4'h0, OK, 32'h0bad_cafe, 3, 3);
    endtask

    task automatic check_idle();
        check_value("hyper_cs_no", 32'(cs_n), 32'd1);
        check_value("hyper_ck_o", 32'(ck), 32'd0);
        check_value("hyper_dq_oe_o", 32'(dq_oe), 32'd0);
        check_value("hyper_rwds_oe_o", 32'(rwds_oe), 32'd0);
        check_value("hyper_reset_no", 32'(reset_n), 32'd1);
        check_value("bvalid", 32'(rsp.bvalid), 32'd0);
        check_value("rvalid", 32'(rsp.rvalid), 32'd0);
        check_value("awready", 32'(rsp.awready), 32'd0);
        check_value("wready", 32'(rsp.wready), 32'd0);
        check_value("arready", 32'(rsp.arready), 32'd0);
    endtask

    task automatic run_row(input row_t r);
        logic [31:0] rdata_seen;
        logic [31:0] resp_seen;
        model_lat = r.lat;
        if (r.write) begin
            req.awaddr  = r.addr;
            req.wdata   = r.data;
            req.wstrb   = r.strb;
            req.awvalid = 1'b1;
            req.wvalid  = 1'b1;
        end else begin
            req.araddr  = r.addr;
            req.arvalid = 1'b1;
        end
        @(negedge clk);
        while (!(r.write ? wr_hs_q : rd_hs_q)) begin
            @(negedge clk);
        end
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        req.arvalid = 1'b0;
        while (!response_valid(r.write)) begin
            @(negedge clk);
        end
        resp_seen  = r.write ? 32'(rsp.bresp) : 32'(rsp.rresp);
        rdata_seen = rsp.rdata;
        check_value(r.write ? "bresp" : "rresp", resp_seen, 32'(r.resp));
        if (!r.write) begin
            check_value("rdata", rdata_seen, r.exp_data);
        end
        // Response must hold while the master stalls
        repeat (r.hold) begin
            @(negedge clk);
            check_value(r.write ? "bvalid" : "rvalid", 32'(response_valid(r.write)), 32'd1);
            check_value(r.write ? "bresp" : "rresp",
                        r.write ? 32'(rsp.bresp) : 32'(rsp.rresp), resp_seen);
            check_value("rdata", rsp.rdata, rdata_seen);
        end
        req.bready = r.write;
        req.rready = !r.write;
        @(negedge clk);
        req.bready = 1'b0;
        req.rready = 1'b0;
        check_value(r.write ? "bvalid" : "rvalid", 32'(response_valid(r.write)), 32'd0);
        assert (!bus_err) else begin
            fail_now("memory model saw a malformed HyperBus cycle");
        end
    endtask

    initial begin
        req       = '0;
        reset     = 1'b1;
        model_lat = 4'd6;
        cycle_cnt = 0;
        load_rows();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
